// ==== include/line_mem_defs.svh ====
`ifndef LINE_MEM_DEFS_SVH
`define LINE_MEM_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// field widths shared by the package and the testbench
//////////////////////////////////////////////////////////////////////

// requester tag, wide enough for 16 outstanding ids
`define LM_TAG_W 4

// one mask bit per 16-bit halfword of a 64-bit line
`define LM_HWMASK_W 4

`endif

// ==== source/line_mem_pkg.sv ====
`include "line_mem_defs.svh"

package line_mem_pkg;

  //////////////////////////////////////////////////////////////////////
  // line geometry
  //////////////////////////////////////////////////////////////////////
  localparam int LINE_W = 64;              // bits per line
  localparam int HW_W   = 16;              // bits per halfword
  localparam int NUM_HW = `LM_HWMASK_W;    // halfwords per line, one mask bit each

  // 16384 lines -> 14 bit line address
  localparam int ADDR_W = 14;

  //////////////////////////////////////////////////////////////////////
  // bank split
  //////////////////////////////////////////////////////////////////////
  localparam int NUM_BANKS  = 4;                    // interleaved on addr[1:0]
  localparam int BANK_SEL_W = $clog2(NUM_BANKS);    // 2
  localparam int ROW_W      = ADDR_W - BANK_SEL_W;  // 12, 4096 rows per bank

  // clocks a bank spends in its busy state before the access edge
  localparam int ACCESS_CLKS = 4;

  localparam int TAG_W = `LM_TAG_W;   // tag width, same value the testbench sees

  //////////////////////////////////////////////////////////////////////
  // request and response records
  //////////////////////////////////////////////////////////////////////

  // request as seen on the external port, 87 bits
  typedef struct packed {
    logic              write;    // 1 = line write, 0 = line read
    logic [ADDR_W-1:0] addr;     // line address, low bits pick the bank
    logic [NUM_HW-1:0] wmask;    // halfword enables, writes only
    logic [LINE_W-1:0] wdata;    // write line
    logic [TAG_W-1:0]  tag;      // echoed back in the response
  } mem_req_t;

  // same request once the bank bits are stripped off
  typedef struct packed {
    logic              write;
    logic [ROW_W-1:0]  row;      // row inside the selected bank
    logic [NUM_HW-1:0] wmask;
    logic [LINE_W-1:0] wdata;
    logic [TAG_W-1:0]  tag;
  } bank_req_t;

  // response, 69 bits
  typedef struct packed {
    logic              write;    // set for a write acknowledge
    logic [LINE_W-1:0] data;     // read line, zero on writes
    logic [TAG_W-1:0]  tag;
  } mem_rsp_t;

endpackage

// ==== source/bank_dispatch.sv ====
`timescale 1ns/10ps

module bank_dispatch (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 req_valid,  // one-cycle request strobe
  input  line_mem_pkg::mem_req_t               req,
  input  logic [line_mem_pkg::NUM_BANKS-1:0]   bank_rdy,   // raw ready from each bank
  output logic [line_mem_pkg::NUM_BANKS-1:0]   bank_ready, // ready as seen by the requester
  output logic                                 req_drop,   // request hit a busy bank
  output logic [line_mem_pkg::NUM_BANKS-1:0]   start,      // one-hot start strobe
  output line_mem_pkg::bank_req_t              bank_req    // shared by all banks
);

  import line_mem_pkg::*;

  logic [BANK_SEL_W-1:0] sel;       // target bank
  logic [ROW_W-1:0]      row;       // address with the bank bits cut away
  logic [NUM_BANKS-1:0]  sel_dec;   // sel as one-hot
  logic                  accept;

  //////////////////////////////////////////////////////////////////////
  // bank decode
  //////////////////////////////////////////////////////////////////////
  assign sel = req.addr[BANK_SEL_W-1:0];    // low address bits interleave the banks
  assign row = req.addr[ADDR_W-1:BANK_SEL_W];

  always_comb begin
    sel_dec      = '0;
    sel_dec[sel] = 1'b1;
  end

  // a bank whose start is still in flight has not dropped rdy yet,
  // so it is masked here for that one cycle
  assign bank_ready = bank_rdy & ~start;

  assign accept = req_valid & bank_ready[sel];

  //////////////////////////////////////////////////////////////////////
  // control registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start    <= '0;
      req_drop <= 1'b0;
    end else begin
      start    <= accept ? sel_dec : '0;            // single-cycle pulse to one bank
      req_drop <= req_valid & ~bank_ready[sel];     // busy target, request lost
    end
  end

  // request payload, loaded only on accept so it holds while start is high
  always_ff @(posedge clk) begin
    if (accept) begin
      bank_req.write <= req.write;
      bank_req.row   <= row;
      bank_req.wmask <= req.wmask;
      bank_req.wdata <= req.wdata;
      bank_req.tag   <= req.tag;
    end
  end

endmodule

// ==== source/line_bank.sv ====
`timescale 1ns/10ps

module line_bank (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,      // one-cycle start from the dispatcher
  input  line_mem_pkg::bank_req_t bank_req,
  output logic                    rdy,        // high only while idle
  output logic                    done,       // one-cycle completion strobe
  output line_mem_pkg::mem_rsp_t  rsp
);

  import line_mem_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // state machine encoding
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    WRITE = 2'b01,
    READ  = 2'b10
  } state_t;

  state_t    state, nxt_state;
  logic [1:0] wait_cnt;       // counts the busy clocks
  logic      clr_cnt;         // hold counter at zero
  logic      int_we, int_re;  // access strobes, high in the last busy cycle
  logic      take;            // start accepted while idle
  logic      last_clk;

  bank_req_t cur_req;         // request held for the whole access

  // 4096 rows, each line split into halfwords for the write mask
  logic [NUM_HW-1:0][HW_W-1:0] mem [0:2**ROW_W-1];

  assign take     = start & (state == IDLE);
  assign last_clk = (wait_cnt == 2'(ACCESS_CLKS - 1));  // fourth busy clock
  assign rdy      = (state == IDLE);

  // latch request so row and data stay stable while counting
  always_ff @(posedge clk) begin
    if (take)
      cur_req <= bank_req;
  end

  //////////////////////////////////////////////////////////////////////
  // state and wait counter
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      wait_cnt <= 2'b00;
    else if (clr_cnt)
      wait_cnt <= 2'b00;
    else
      wait_cnt <= wait_cnt + 2'b01;
  end

  always_comb begin
    clr_cnt   = 1'b1;    // counter parked at zero by default
    int_we    = 1'b0;
    int_re    = 1'b0;
    nxt_state = state;
    case (state)
      IDLE: begin
        if (take)
          nxt_state = bank_req.write ? WRITE : READ;   // counting starts next cycle
      end
      WRITE: begin
        if (last_clk) begin
          int_we    = 1'b1;    // write lands on the coming edge
          nxt_state = IDLE;
        end else begin
          clr_cnt = 1'b0;
        end
      end
      READ: begin
        if (last_clk) begin
          int_re    = 1'b1;
          nxt_state = IDLE;
        end else begin
          clr_cnt = 1'b0;
        end
      end
      default: nxt_state = IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // storage and response
  //////////////////////////////////////////////////////////////////////

  // masked write, untouched halfwords keep their old value
  always_ff @(posedge clk) begin
    if (int_we) begin
      for (int i = 0; i < NUM_HW; i++) begin
        if (cur_req.wmask[i])
          mem[cur_req.row][i] <= cur_req.wdata[i*HW_W +: HW_W];
      end
    end
  end

  // response payload, loaded on the access edge
  always_ff @(posedge clk) begin
    if (int_we | int_re) begin
      rsp.write <= cur_req.write;
      rsp.data  <= int_re ? mem[cur_req.row] : '0;   // writes ack with zero data
      rsp.tag   <= cur_req.tag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      done <= 1'b0;
    else
      done <= int_we | int_re;   // high for the cycle after the access edge
  end

endmodule

// ==== source/rsp_collect.sv ====
`timescale 1ns/10ps

module rsp_collect (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic [line_mem_pkg::NUM_BANKS-1:0]                   done,
  input  line_mem_pkg::mem_rsp_t [line_mem_pkg::NUM_BANKS-1:0] bank_rsp,
  output logic                                                 rsp_valid,
  output line_mem_pkg::mem_rsp_t                               rsp,
  output logic                                                 collide   // sticky
);

  import line_mem_pkg::*;

  mem_rsp_t merged;    // OR of all responses whose done is set
  logic     any_done;
  logic     multi;     // two or more banks finished together

  //////////////////////////////////////////////////////////////////////
  // merge
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    merged = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (done[b])
        merged = merged | bank_rsp[b];
    end
  end

  assign any_done = |done;

  // clearing the lowest set bit leaves something only if two were set
  assign multi = |(done & (done - 1'b1));

  //////////////////////////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
      collide   <= 1'b0;
    end else begin
      rsp_valid <= any_done;         // one strobe per bank completion
      collide   <= collide | multi;  // held until reset
    end
  end

  always_ff @(posedge clk) begin
    if (any_done)
      rsp <= merged;
  end

endmodule

// ==== source/line_mem_top.sv ====
`timescale 1ns/10ps

module line_mem_top (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               req_valid,
  input  line_mem_pkg::mem_req_t             req,
  output logic [line_mem_pkg::NUM_BANKS-1:0] bank_ready,
  output logic                               req_drop,
  output logic                               rsp_valid,
  output line_mem_pkg::mem_rsp_t             rsp,
  output logic                               collide
);

  import line_mem_pkg::*;

  logic [NUM_BANKS-1:0]            bank_rdy;   // per bank idle flag
  logic [NUM_BANKS-1:0]            start;      // one-hot from the dispatcher
  logic [NUM_BANKS-1:0]            done;       // per bank completion
  bank_req_t                       bank_req;   // shared request register
  mem_rsp_t [NUM_BANKS-1:0]        bank_rsp;

  //////////////////////////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////////////////////////
  bank_dispatch u_dispatch (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req        (req),
    .bank_rdy   (bank_rdy),
    .bank_ready (bank_ready),
    .req_drop   (req_drop),
    .start      (start),
    .bank_req   (bank_req)
  );

  // banks interleaved on the low address bits
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    line_bank u_bank (
      .clk      (clk),
      .rst_n    (rst_n),
      .start    (start[b]),
      .bank_req (bank_req),   // only the bank with start set takes it
      .rdy      (bank_rdy[b]),
      .done     (done[b]),
      .rsp      (bank_rsp[b])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // response side
  //////////////////////////////////////////////////////////////////////
  rsp_collect u_collect (
    .clk       (clk),
    .rst_n     (rst_n),
    .done      (done),
    .bank_rsp  (bank_rsp),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .collide   (collide)
  );

endmodule

// ==== verification/line_mem_tb.sv ====
`timescale 1ns/10ps
`include "line_mem_defs.svh"

module line_mem_tb;

  import line_mem_pkg::*;

  localparam int N_FULL    = 24;                          // lines written with every halfword
  localparam int N_MASK    = 16;                          // masked rewrites of those lines
  localparam int NUM_REQS  = 2*N_FULL + 2*N_MASK + 8 + 7; // bursts 8, drop sequence 7
  localparam int RSP_LAT   = ACCESS_CLKS + 2;             // accept edge to response edge
  localparam int WD_CYCLES = 16 + NUM_REQS*8 + 200;

  logic                 clk;
  logic                 rst_n;
  logic                 req_valid;
  mem_req_t             req;
  logic [NUM_BANKS-1:0] bank_ready;
  logic                 req_drop;
  logic                 rsp_valid;
  mem_rsp_t             rsp;
  logic                 collide;

  logic [31:0]          rng_state  = 32'h45668f82;
  logic [`LM_TAG_W-1:0] tag_cnt    = '0;   // wraps, tags only need to differ nearby
  int                   edge_cnt   = 0;    // rising edges seen so far
  int                   val_errs   = 0;
  int                   other_errs = 0;

  logic [NUM_HW-1:0][HW_W-1:0] shadow [0:2**ADDR_W-1];   // reference copy of the storage
  logic [ADDR_W-1:0]           lines [0:N_FULL-1];       // lines with a known value
  mem_rsp_t                    exp_q [$];                // pending responses, issue order
  int                          edge_q [$];               // accept edge of each entry
  int                          busy_until [NUM_BANKS] = '{default: -1};
  logic                        drop_pend = 1'b0;         // req_drop due after next edge

  line_mem_top dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req        (req),
    .bank_ready (bank_ready),
    .req_drop   (req_drop),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .collide    (collide)
  );

  ////////////////////////////////////////////////////////////////////////
  // clock, edge count, watchdog
  ////////////////////////////////////////////////////////////////////////
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;   // 20 ns period
  end

  always @(posedge clk)
    edge_cnt <= edge_cnt + 1;

  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("run timed out after %0d cycles with %0d responses pending",
             WD_CYCLES, exp_q.size());
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;   // lcg step
    return rng_state;
  endfunction

  function automatic mem_req_t make_req(input logic              wr,
                                        input logic [ADDR_W-1:0] addr,
                                        input logic [NUM_HW-1:0] mask,
                                        input logic [LINE_W-1:0] data);
    mem_req_t r;
    r.write = wr;
    r.addr  = addr;
    r.wmask = mask;
    r.wdata = data;
    r.tag   = tag_cnt;
    tag_cnt = tag_cnt + 1'b1;   // fresh tag per request
    return r;
  endfunction

  // wait for the target bank, strobe once, return on the accept edge
  task automatic issue(input mem_req_t r);
    @(negedge clk);
    while (!bank_ready[r.addr[BANK_SEL_W-1:0]])
      @(negedge clk);
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= r;
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  // one request per bank on four consecutive edges, same row in each
  task automatic burst(input logic wr, input logic [ROW_W-1:0] row);
    mem_req_t r;
    @(negedge clk);
    while (bank_ready != '1)
      @(negedge clk);
    for (int b = 0; b < NUM_BANKS; b++) begin
      r = make_req(wr, {row, BANK_SEL_W'(b)}, '1, {next_rand(), next_rand()});
      @(posedge clk);
      req_valid <= 1'b1;
      req       <= r;
    end
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  // hammer a busy bank, every strobe must be dropped
  task automatic drop_check();
    logic [ADDR_W-1:0] addr;
    mem_req_t          r;
    addr = ADDR_W'(next_rand() >> 8);
    issue(make_req(1'b1, addr, '1, {next_rand(), next_rand()}));
    repeat (5) begin   // edges t+1 .. t+5 all see the bank busy
      r = make_req(1'b1, addr, '1, {next_rand(), next_rand()});
      req_valid <= 1'b1;
      req       <= r;
      @(posedge clk);
    end
    req_valid <= 1'b0;
    issue(make_req(1'b0, addr, '0, '0));   // still the first write's line
  endtask

  ////////////////////////////////////////////////////////////////////////
  // monitor, sampled at the falling edge where outputs are stable
  ////////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin : monitor
    logic [NUM_BANKS-1:0]  exp_ready;
    mem_rsp_t              exp_rsp;
    int                    acc;
    logic [BANK_SEL_W-1:0] b;
    if (rst_n) begin
      for (int i = 0; i < NUM_BANKS; i++)
        exp_ready[i] = (busy_until[i] < edge_cnt);   // low from accept edge to t+4
      assert (bank_ready === exp_ready) else begin
        val_errs++;
        $display("FAILED bank_ready: expected %h, got %h", exp_ready, bank_ready);
      end
      assert (req_drop === drop_pend) else begin
        val_errs++;
        $display("FAILED req_drop: expected %h, got %h", drop_pend, req_drop);
      end
      assert (collide === 1'b0) else begin
        val_errs++;
        $display("FAILED collide: expected %h, got %h", 1'b0, collide);
      end

      // response against the queue head
      if (rsp_valid) begin
        assert (exp_q.size() != 0) else begin
          other_errs++;
          $display("response at edge %0d with nothing pending", edge_cnt);
        end
        if (exp_q.size() != 0) begin
          exp_rsp = exp_q.pop_front();
          acc     = edge_q.pop_front();
          assert (edge_cnt == acc + RSP_LAT) else begin
            other_errs++;
            $display("response with tag %h came %0d edges after accept, not %0d",
                     rsp.tag, edge_cnt - acc, RSP_LAT);
          end
          assert (rsp.write === exp_rsp.write) else begin
            val_errs++;
            $display("FAILED rsp.write: expected %h, got %h", exp_rsp.write, rsp.write);
          end
          assert (rsp.data === exp_rsp.data) else begin
            val_errs++;
            $display("FAILED rsp.data: expected %h, got %h", exp_rsp.data, rsp.data);
          end
          assert (rsp.tag === exp_rsp.tag) else begin
            val_errs++;
            $display("FAILED rsp.tag: expected %h, got %h", exp_rsp.tag, rsp.tag);
          end
        end
      end else if (edge_q.size() != 0) begin
        assert (edge_q[0] + RSP_LAT > edge_cnt) else begin
          other_errs++;
          $display("no response for tag %h by edge %0d", exp_q[0].tag, edge_cnt);
          exp_rsp = exp_q.pop_front();   // discard so later ones still line up
          acc     = edge_q.pop_front();
        end
      end

      // what the coming edge does with the strobe now on the port
      drop_pend = 1'b0;
      if (req_valid) begin
        b = req.addr[BANK_SEL_W-1:0];
        if (exp_ready[b]) begin
          busy_until[b] = edge_cnt + 1 + ACCESS_CLKS;
          exp_rsp.write = req.write;
          exp_rsp.tag   = req.tag;
          if (req.write)
            exp_rsp.data = '0;   // write ack
          else
            exp_rsp.data = shadow[req.addr];
          exp_q.push_back(exp_rsp);
          edge_q.push_back(edge_cnt + 1);
          if (req.write) begin
            for (int h = 0; h < NUM_HW; h++)
              if (req.wmask[h])
                shadow[req.addr][h] = req.wdata[h*HW_W +: HW_W];
          end
        end else begin
          drop_pend = 1'b1;   // busy bank, nothing queued, shadow untouched
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////
  initial begin
    logic [ROW_W-1:0] row;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // idle state right after reset
    @(negedge clk);
    assert (bank_ready === '1) else begin
      val_errs++;
      $display("FAILED bank_ready: expected %h, got %h", {NUM_BANKS{1'b1}}, bank_ready);
    end
    assert (rsp_valid === 1'b0) else begin
      val_errs++;
      $display("FAILED rsp_valid: expected %h, got %h", 1'b0, rsp_valid);
    end
    assert (req_drop === 1'b0) else begin
      val_errs++;
      $display("FAILED req_drop: expected %h, got %h", 1'b0, req_drop);
    end
    assert (collide === 1'b0) else begin
      val_errs++;
      $display("FAILED collide: expected %h, got %h", 1'b0, collide);
    end

    // full-line writes, then read them all back
    for (int i = 0; i < N_FULL; i++) begin
      lines[i] = ADDR_W'(next_rand() >> 8);
      issue(make_req(1'b1, lines[i], '1, {next_rand(), next_rand()}));
    end
    for (int i = 0; i < N_FULL; i++)
      issue(make_req(1'b0, lines[i], '0, '0));

    // partial writes over known lines, each read back at once
    for (int i = 0; i < N_MASK; i++) begin
      issue(make_req(1'b1, lines[i], NUM_HW'(next_rand() >> 20), {next_rand(), next_rand()}));
      issue(make_req(1'b0, lines[i], '0, '0));
    end

    // all four banks in flight together
    row = ROW_W'(next_rand() >> 12);
    burst(1'b1, row);
    burst(1'b0, row);

    drop_check();

    while (exp_q.size() != 0)   // watchdog covers a lost response
      @(negedge clk);
    repeat (10) @(negedge clk);  // catch stray strobes

    $display("checks done: %0d value errors, %0d other errors", val_errs, other_errs);
    if (val_errs + other_errs == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+include
source/line_mem_pkg.sv
source/bank_dispatch.sv
source/line_bank.sv
source/rsp_collect.sv
source/line_mem_top.sv
verification/line_mem_tb.sv
